//--- hw/adc_capture_pkg.sv
// shared types and register constants for the adc capture core, imported by every rtl module

package adc_capture_pkg;

  // ******************************
  // lane geometry
  // ******************************

  // fourteen data lanes, four serial bits per lane per divided clock
  localparam int ADC_LANES = 14;
  localparam int ADC_BEATS = 4;

  // raw deserializer output of one cycle, beat index k is bit s<k>, s0 oldest
  typedef struct packed {
    logic [ADC_BEATS-1:0]                or_lane;
    logic [ADC_LANES-1:0][ADC_BEATS-1:0] data;
  } adc_lane_beats_t;

  // per-lane bit delay, 0 to 3 bit times
  typedef struct packed {
    logic [1:0]                or_tap;
    logic [ADC_LANES-1:0][1:0] data_tap;
  } adc_tap_cfg_t;

  // two samples per channel, high half is the older sample
  typedef struct packed {
    logic [2*ADC_LANES-1:0] data_a;
    logic                   or_a;
    logic [2*ADC_LANES-1:0] data_b;
    logic                   or_b;
  } adc_sample_t;

  // ******************************
  // axi4-lite
  // ******************************

  typedef struct packed {
    logic        awvalid;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [7:0]  araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  typedef enum logic {
    axil_idle,
    axil_resp
  } axil_state_e;

  // register map
  typedef enum logic [7:0] {
    reg_id       = 8'h00,
    reg_ctrl     = 8'h04,
    reg_status   = 8'h08,
    reg_tap_data = 8'h10,
    reg_tap_or   = 8'h14
  } adc_reg_addr_e;

  localparam logic [31:0] ADC_CORE_ID      = 32'h0ad96840;
  localparam logic [1:0]  AXIL_RESP_OKAY   = 2'b00;
  localparam int          CTRL_CAPTURE_BIT = 0;
  localparam int          STAT_LOCK_BIT    = 0;
  localparam int          STAT_OR_A_BIT    = 1;
  localparam int          STAT_OR_B_BIT    = 2;

endpackage

//--- hw/adc_lane_align.sv
// per-lane bit-slip delay line, re-aligns each four-bit lane beat by its tap before de-interleave
`timescale 1ns/1ns

module adc_lane_align #(
  parameter int OR_STATUS = 0
) (
  input  logic                             adc_div_clk,
  input  logic                             adc_rst,
  input  adc_capture_pkg::adc_lane_beats_t pins,
  input  adc_capture_pkg::adc_tap_cfg_t    taps,
  output adc_capture_pkg::adc_lane_beats_t aligned
);

  import adc_capture_pkg::*;

  // previous beat of every lane, needed when the window reaches back
  logic [ADC_LANES-1:0][ADC_BEATS-1:0] prev_data;
  logic [ADC_LANES-1:0][ADC_BEATS-1:0] aligned_data;
  logic [ADC_BEATS-1:0]                aligned_or;

  // eight-bit history is {current, previous}, previous holds the older bits
  // output bit k takes stream bit k - tap
  function automatic logic [ADC_BEATS-1:0] lane_window(
    input logic [ADC_BEATS-1:0] cur,
    input logic [ADC_BEATS-1:0] prev,
    input logic [1:0]           tap
  );
    logic [2*ADC_BEATS-1:0] hist;
    logic [2*ADC_BEATS-1:0] shifted;
    hist    = {cur, prev};
    shifted = hist >> (ADC_BEATS - int'(tap));
    return shifted[ADC_BEATS-1:0];
  endfunction

  // ******************************
  // data lanes
  // ******************************

  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      prev_data    <= '0;
      aligned_data <= '0;
    end else begin
      prev_data <= pins.data;
      for (int i = 0; i < ADC_LANES; i++) begin
        aligned_data[i] <= lane_window(pins.data[i], prev_data[i], taps.data_tap[i]);
      end
    end
  end

  // ******************************
  // over-range lane
  // ******************************

  generate
    if (OR_STATUS == 1) begin : g_or_lane
      logic [ADC_BEATS-1:0] prev_or;

      always_ff @(posedge adc_div_clk) begin
        if (adc_rst) begin
          prev_or    <= '0;
          aligned_or <= '0;
        end else begin
          prev_or    <= pins.or_lane;
          aligned_or <= lane_window(pins.or_lane, prev_or, taps.or_tap);
        end
      end
    end else begin : g_no_or_lane
      // lane not present, keep it quiet
      assign aligned_or = '0;
    end
  endgenerate

  assign aligned.data    = aligned_data;
  assign aligned.or_lane = aligned_or;

  // known pins and taps must give a known aligned word once out of reset
  assert property (@(posedge adc_div_clk) disable iff (adc_rst)
    !$isunknown({pins, taps}) |=> !$isunknown(aligned))
    else $error("aligned beats unknown after reset");

endmodule

//--- hw/adc_sample_demux.sv
// de-interleaves aligned ddr beats into channel a/b sample pairs and derives over-range flags
`timescale 1ns/1ns

module adc_sample_demux #(
  parameter int OR_STATUS = 0
) (
  input  logic                             adc_div_clk,
  input  logic                             adc_rst,
  input  adc_capture_pkg::adc_lane_beats_t aligned,
  input  logic                             capture_en,
  output adc_capture_pkg::adc_sample_t     samples,
  output logic                             adc_valid
);

  import adc_capture_pkg::*;

  localparam logic OR_EN = (OR_STATUS == 1);

  // capture_en delayed to line up with the sample stage
  logic en_q;

  // enable pipe, two stages in total from the control register
  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      en_q      <= 1'b0;
      adc_valid <= 1'b0;
    end else begin
      en_q      <= capture_en;
      adc_valid <= en_q;
    end
  end

  // ******************************
  // beat to channel mapping
  // ******************************

  // s0 -> b high, s1 -> a high, s2 -> b low, s3 -> a low
  always_ff @(posedge adc_div_clk) begin
    for (int i = 0; i < ADC_LANES; i++) begin
      samples.data_b[ADC_LANES+i] <= aligned.data[i][0];
      samples.data_a[ADC_LANES+i] <= aligned.data[i][1];
      samples.data_b[i]           <= aligned.data[i][2];
      samples.data_a[i]           <= aligned.data[i][3];
    end
    // or lane carries one flag per sample, combine both of a channel
    samples.or_a <= OR_EN & (aligned.or_lane[1] | aligned.or_lane[3]);
    samples.or_b <= OR_EN & (aligned.or_lane[0] | aligned.or_lane[2]);
  end

  // without the or lane no over-range may ever be reported
  assert property (@(posedge adc_div_clk) disable iff (adc_rst)
    (OR_STATUS == 0) |-> (!samples.or_a && !samples.or_b))
    else $error("over-range flag set with OR_STATUS 0");

endmodule

//--- hw/adc_if_core.sv
// adc interface core, chains lane alignment and de-interleave and syncs the lock status
`timescale 1ns/1ns

module adc_if_core #(
  parameter int OR_STATUS = 0
) (
  input  logic                             adc_div_clk,
  input  logic                             adc_rst,
  input  adc_capture_pkg::adc_lane_beats_t pins,
  input  logic                             pll_locked,
  input  adc_capture_pkg::adc_tap_cfg_t    taps,
  input  logic                             capture_en,
  output adc_capture_pkg::adc_sample_t     samples,
  output logic                             adc_valid,
  output logic                             adc_status
);

  import adc_capture_pkg::*;

  // beats after the bit-slip stage
  adc_lane_beats_t aligned;

  // first flop of the lock synchronizer
  logic locked_m1;

  // ******************************
  // data path
  // ******************************

  adc_lane_align #(
    .OR_STATUS(OR_STATUS)
  ) i_lane_align (
    .adc_div_clk(adc_div_clk),
    .adc_rst    (adc_rst),
    .pins       (pins),
    .taps       (taps),
    .aligned    (aligned)
  );

  adc_sample_demux #(
    .OR_STATUS(OR_STATUS)
  ) i_sample_demux (
    .adc_div_clk(adc_div_clk),
    .adc_rst    (adc_rst),
    .aligned    (aligned),
    .capture_en (capture_en),
    .samples    (samples),
    .adc_valid  (adc_valid)
  );

  // ******************************
  // status
  // ******************************

  // pll lock comes from another domain, two flops before use
  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      locked_m1  <= 1'b0;
      adc_status <= 1'b0;
    end else begin
      locked_m1  <= pll_locked;
      adc_status <= locked_m1;
    end
  end

endmodule

//--- hw/adc_axil_regs.sv
// axi4-lite register block with id, control, status with sticky over-range, and tap registers
`timescale 1ns/1ns

module adc_axil_regs #(
  parameter int OR_STATUS = 0
) (
  input  logic                          adc_div_clk,
  input  logic                          adc_rst,
  input  adc_capture_pkg::axil_req_t    axil_req,
  output adc_capture_pkg::axil_rsp_t    axil_rsp,
  input  adc_capture_pkg::adc_sample_t  samples,
  input  logic                          adc_valid,
  input  logic                          adc_status,
  output adc_capture_pkg::adc_tap_cfg_t taps,
  output logic                          capture_en
);

  import adc_capture_pkg::*;

  axil_state_e   wr_state;
  axil_state_e   rd_state;
  adc_reg_addr_e wr_addr;
  adc_reg_addr_e rd_addr;
  logic          wr_fire;
  logic          rd_fire;
  logic [31:0]   wr_word;
  logic [31:0]   w1c_mask;
  logic [31:0]   rdata_q;
  logic          or_a_q;
  logic          or_b_q;
  logic          set_a;
  logic          set_b;
  logic          clr_a;
  logic          clr_b;

  // byte lanes without strobe keep the old value
  function automatic logic [31:0] merge_strb(
    input logic [31:0] old_val,
    input logic [31:0] new_val,
    input logic [3:0]  strb
  );
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = strb[b] ? new_val[8*b +: 8] : old_val[8*b +: 8];
    end
    return res;
  endfunction

  // current register contents as seen from the bus
  function automatic logic [31:0] reg_read(input adc_reg_addr_e addr);
    case (addr)
      reg_id:       return ADC_CORE_ID;
      reg_ctrl:     return {31'b0, capture_en};
      reg_status:   return {29'b0, or_b_q, or_a_q, adc_status};
      reg_tap_data: return {4'b0, taps.data_tap};
      reg_tap_or:   return (OR_STATUS == 1) ? {30'b0, taps.or_tap} : 32'h0;
      default:      return 32'h0;
    endcase
  endfunction

  assign wr_addr = adc_reg_addr_e'(axil_req.awaddr);
  assign rd_addr = adc_reg_addr_e'(axil_req.araddr);

  // address and data must arrive together
  assign wr_fire  = (wr_state == axil_idle) && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire  = (rd_state == axil_idle) && axil_req.arvalid;
  assign wr_word  = merge_strb(reg_read(wr_addr), axil_req.wdata, axil_req.wstrb);
  assign w1c_mask = merge_strb(32'h0, axil_req.wdata, axil_req.wstrb);

  // ******************************
  // handshake
  // ******************************

  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      wr_state <= axil_idle;
      rd_state <= axil_idle;
    end else begin
      if (wr_fire) begin
        wr_state <= axil_resp;
      end else if (wr_state == axil_resp && axil_req.bready) begin
        wr_state <= axil_idle;
      end
      if (rd_fire) begin
        rd_state <= axil_resp;
      end else if (rd_state == axil_resp && axil_req.rready) begin
        rd_state <= axil_idle;
      end
    end
  end

  // read data is captured at accept and held through the response
  always_ff @(posedge adc_div_clk) begin
    if (rd_fire) begin
      rdata_q <= reg_read(rd_addr);
    end
  end

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bvalid  = (wr_state == axil_resp);
    axil_rsp.bresp   = AXIL_RESP_OKAY;
    axil_rsp.arready = rd_fire;
    axil_rsp.rvalid  = (rd_state == axil_resp);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = AXIL_RESP_OKAY;
  end

  // ******************************
  // control and tap registers
  // ******************************

  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      capture_en <= 1'b0;
      taps       <= '0;
    end else if (wr_fire) begin
      case (wr_addr)
        reg_ctrl:     capture_en <= wr_word[CTRL_CAPTURE_BIT];
        reg_tap_data: taps.data_tap <= wr_word[2*ADC_LANES-1:0];
        reg_tap_or: begin
          // or tap only exists with the or lane
          if (OR_STATUS == 1) begin
            taps.or_tap <= wr_word[1:0];
          end
        end
        default: ;
      endcase
    end
  end

  // ******************************
  // sticky over-range
  // ******************************

  assign set_a = adc_valid && samples.or_a;
  assign set_b = adc_valid && samples.or_b;
  assign clr_a = wr_fire && (wr_addr == reg_status) && w1c_mask[STAT_OR_A_BIT];
  assign clr_b = wr_fire && (wr_addr == reg_status) && w1c_mask[STAT_OR_B_BIT];

  // a new over-range wins over a clear in the same cycle
  always_ff @(posedge adc_div_clk) begin
    if (adc_rst) begin
      or_a_q <= 1'b0;
      or_b_q <= 1'b0;
    end else begin
      or_a_q <= set_a | (or_a_q & ~clr_a);
      or_b_q <= set_b | (or_b_q & ~clr_b);
    end
  end

  // responses stay up with stable data until the master takes them
  assert property (@(posedge adc_div_clk) disable iff (adc_rst)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

  assert property (@(posedge adc_div_clk) disable iff (adc_rst)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else $error("rvalid or rdata changed before rready");

endmodule

//--- hw/adc_capture_top.sv
// top level of the adc capture core, joins the interface core with its axi4-lite registers
`timescale 1ns/1ns

module adc_capture_top #(
  parameter int OR_STATUS = 1
) (
  input  logic                             adc_div_clk,
  input  logic                             adc_rst,
  input  adc_capture_pkg::adc_lane_beats_t pins,
  input  logic                             pll_locked,
  input  adc_capture_pkg::axil_req_t       axil_req,
  output adc_capture_pkg::axil_rsp_t       axil_rsp,
  output adc_capture_pkg::adc_sample_t     samples,
  output logic                             adc_valid
);

  import adc_capture_pkg::*;

  // register block to core
  adc_tap_cfg_t taps;
  logic         capture_en;
  // core back to registers
  logic         adc_status;

  adc_if_core #(
    .OR_STATUS(OR_STATUS)
  ) i_if_core (
    .adc_div_clk(adc_div_clk),
    .adc_rst    (adc_rst),
    .pins       (pins),
    .pll_locked (pll_locked),
    .taps       (taps),
    .capture_en (capture_en),
    .samples    (samples),
    .adc_valid  (adc_valid),
    .adc_status (adc_status)
  );

  adc_axil_regs #(
    .OR_STATUS(OR_STATUS)
  ) i_axil_regs (
    .adc_div_clk(adc_div_clk),
    .adc_rst    (adc_rst),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .samples    (samples),
    .adc_valid  (adc_valid),
    .adc_status (adc_status),
    .taps       (taps),
    .capture_en (capture_en)
  );

endmodule

//--- test/adc_capture_tb.sv
// table-driven testbench for adc_capture_top that the Makefile test target runs through the file list
`timescale 1ns/1ns

module adc_capture_tb;

  import adc_capture_pkg::*;

  localparam int ENTRIES       = 6;
  localparam int STREAM_LEN    = 6;
  localparam int AXIL_TIMEOUT  = 32;
  localparam int VALID_TIMEOUT = 16;

  // one table row holds a pin word, a tap setting and the over-range expected on that word
  typedef struct packed {
    adc_lane_beats_t pins;
    adc_tap_cfg_t    taps;
    logic            or_exp;
  } stim_t;

  logic            adc_div_clk;
  logic            adc_rst;
  adc_lane_beats_t pins;
  logic            pll_locked;
  axil_req_t       axil_req;
  axil_rsp_t       axil_rsp;
  adc_sample_t     samples;
  logic            adc_valid;

  stim_t       stim_table [0:ENTRIES-1];
  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;
  int          last_wr_edge;
  int          mismatches;
  int          timeouts;
  int          waited;
  logic        sticky_a;
  logic        sticky_b;

  adc_capture_top #(
    .OR_STATUS(1)
  ) UUT (
    .adc_div_clk(adc_div_clk),
    .adc_rst    (adc_rst),
    .pins       (pins),
    .pll_locked (pll_locked),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .samples    (samples),
    .adc_valid  (adc_valid)
  );

  // 100 ns period
  always #50 adc_div_clk = ~adc_div_clk;

  // rising edges counted for latency checks
  always @(posedge adc_div_clk) cycle_cnt <= cycle_cnt + 1;

  // ******************************
  // stimulus helpers
  // ******************************

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // filler word with random data lanes and a quiet or lane so only table rows flag over-range
  task automatic random_pins(output adc_lane_beats_t w);
    w = '0;
    for (int b = 0; b < ADC_LANES * ADC_BEATS; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w.data[b / ADC_BEATS][b % ADC_BEATS] = lfsr_state[0];
    end
  endtask

  // ******************************
  // reference model
  // ******************************

  // beat k with tap t is stream bit k-t and negative positions come from the older beat
  function automatic logic [ADC_BEATS-1:0] slip_beat(
    input logic [ADC_BEATS-1:0] cur,
    input logic [ADC_BEATS-1:0] prev,
    input logic [1:0]           tap
  );
    logic [ADC_BEATS-1:0] r;
    int                   src;
    for (int k = 0; k < ADC_BEATS; k++) begin
      src = k - int'(tap);
      if (src >= 0) r[k] = cur[src];
      else r[k] = prev[src + ADC_BEATS];
    end
    return r;
  endfunction

  // s0 to b high, s1 to a high, s2 to b low, s3 to a low
  function automatic adc_sample_t model_sample(
    input adc_lane_beats_t cur,
    input adc_lane_beats_t prev,
    input adc_tap_cfg_t    t
  );
    adc_sample_t          s;
    logic [ADC_BEATS-1:0] a;
    s = '0;
    for (int i = 0; i < ADC_LANES; i++) begin
      a = slip_beat(cur.data[i], prev.data[i], t.data_tap[i]);
      s.data_b[ADC_LANES+i] = a[0];
      s.data_a[ADC_LANES+i] = a[1];
      s.data_b[i]           = a[2];
      s.data_a[i]           = a[3];
    end
    a = slip_beat(cur.or_lane, prev.or_lane, t.or_tap);
    s.or_a = a[1] | a[3];
    s.or_b = a[0] | a[2];
    return s;
  endfunction

  // ******************************
  // axi4-lite master
  // ******************************

  // called right after a falling edge so the edge count at bvalid is the accept edge
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    int n;
    n = 0;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    @(negedge adc_div_clk);
    while (!axil_rsp.bvalid && n < AXIL_TIMEOUT) begin
      @(negedge adc_div_clk);
      n++;
    end
    last_wr_edge = cycle_cnt;
    // request still held while the response is pending
    if (axil_rsp.bvalid && (axil_rsp.awready || axil_rsp.wready)) begin
      mismatches++;
      $display("MISMATCH at %0t: write to %h accepted again while bvalid is pending",
               $time, addr);
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    if (!axil_rsp.bvalid) begin
      timeouts++;
      $display("timeout: no write response for address %h at %0t", addr, $time);
      return;
    end
    if (axil_rsp.bresp !== AXIL_RESP_OKAY) begin
      mismatches++;
      $display("MISMATCH at %0t: bresp %b for address %h, expected OKAY",
               $time, axil_rsp.bresp, addr);
    end
    axil_req.bready = 1'b1;
    @(negedge adc_div_clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    int n;
    n    = 0;
    data = '0;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    @(negedge adc_div_clk);
    while (!axil_rsp.rvalid && n < AXIL_TIMEOUT) begin
      @(negedge adc_div_clk);
      n++;
    end
    // request still held while the read data is pending
    if (axil_rsp.rvalid && axil_rsp.arready) begin
      mismatches++;
      $display("MISMATCH at %0t: read of %h accepted again while rvalid is pending",
               $time, addr);
    end
    axil_req.arvalid = 1'b0;
    if (!axil_rsp.rvalid) begin
      timeouts++;
      $display("timeout: no read data for address %h at %0t", addr, $time);
      return;
    end
    if (axil_rsp.rresp !== AXIL_RESP_OKAY) begin
      mismatches++;
      $display("MISMATCH at %0t: rresp %b for address %h, expected OKAY",
               $time, axil_rsp.rresp, addr);
    end
    data           = axil_rsp.rdata;
    axil_req.rready = 1'b1;
    @(negedge adc_div_clk);
    axil_req.rready = 1'b0;
  endtask

  task automatic expect_reg(input logic [7:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] got;
    axil_read(addr, got);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ******************************
  // streaming one table row
  // ******************************

  // a filler word and the table word, then fillers that flush any spill of the table word
  task automatic run_entry(input int idx);
    adc_lane_beats_t drv [0:STREAM_LEN-1];
    adc_lane_beats_t prv [0:STREAM_LEN-1];
    adc_sample_t     exp_s;
    for (int c = 0; c < STREAM_LEN + 2; c++) begin
      @(negedge adc_div_clk);
      // word driven two falling edges ago is on samples now
      if (c >= 2) begin
        exp_s = model_sample(drv[c-2], prv[c-2], stim_table[idx].taps);
        if (samples !== exp_s || adc_valid !== 1'b1) begin
          mismatches++;
          $display("MISMATCH at %0t: row %0d word %0d samples %h valid %b, expected %h",
                   $time, idx, c - 2, samples, adc_valid, exp_s);
        end
        if (c == 3 && (samples.or_a | samples.or_b) !== stim_table[idx].or_exp) begin
          mismatches++;
          $display("MISMATCH at %0t: row %0d over-range a %b b %b, table expects %b",
                   $time, idx, samples.or_a, samples.or_b, stim_table[idx].or_exp);
        end
        sticky_a = sticky_a | exp_s.or_a;
        sticky_b = sticky_b | exp_s.or_b;
      end
      if (c < STREAM_LEN) begin
        prv[c] = pins;
        if (c == 1) drv[c] = stim_table[idx].pins;
        else random_pins(drv[c]);
        pins = drv[c];
      end
    end
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial begin
    adc_div_clk = 1'b0;
    adc_rst     = 1'b1;
    pins        = '0;
    pll_locked  = 1'b0;
    axil_req    = '0;
    lfsr_state  = 32'h3ff35a8f;
    mismatches  = 0;
    timeouts    = 0;
    sticky_a    = 1'b0;
    sticky_b    = 1'b0;

    // rows pack pins as {or lane, data lanes} and taps as {or tap, data taps} before the flag
    stim_table[0] = {{4'h0, 56'h0123_4567_89ab_cd}, {2'd0, 28'h000_0000}, 1'b0};
    stim_table[1] = {{4'h0, 56'hf0e1_d2c3_b4a5_96}, {2'd0, 28'he4e_4e4e}, 1'b0};
    stim_table[2] = {{4'h2, 56'h5a5a_c3c3_0ff0_81}, {2'd1, 28'h1b1_b1b1}, 1'b1};
    // or bit spills into the following word
    stim_table[3] = {{4'h8, 56'h8765_4321_fedc_ba}, {2'd2, 28'h555_5555}, 1'b0};
    stim_table[4] = {{4'h1, 56'h3c96_a50f_7e18_e7}, {2'd3, 28'haaa_aaaa}, 1'b1};
    stim_table[5] = {{4'h5, 56'hdead_beef_1234_56}, {2'd0, 28'h000_0000}, 1'b1};

    repeat (3) @(negedge adc_div_clk);
    adc_rst = 1'b0;
    @(negedge adc_div_clk);

    // reset values
    if (adc_valid !== 1'b0) begin
      mismatches++;
      $display("MISMATCH at %0t: adc_valid %b after reset", $time, adc_valid);
    end
    if (axil_rsp.awready !== 1'b0 || axil_rsp.wready !== 1'b0 ||
        axil_rsp.arready !== 1'b0 || axil_rsp.bvalid !== 1'b0 ||
        axil_rsp.rvalid !== 1'b0) begin
      mismatches++;
      $display("MISMATCH at %0t: axi response %h after reset, expected no ready or valid",
               $time, axil_rsp);
    end
    expect_reg(reg_id, ADC_CORE_ID, "reg_id");
    expect_reg(reg_ctrl, 32'h0, "reg_ctrl after reset");
    expect_reg(reg_status, 32'h0, "reg_status after reset");
    expect_reg(8'h20, 32'h0, "unmapped address");

    axil_write(reg_ctrl, 32'h1);
    expect_reg(reg_ctrl, 32'h1, "reg_ctrl enabled");

    for (int e = 0; e < ENTRIES; e++) begin
      axil_write(reg_tap_data, {4'b0, stim_table[e].taps.data_tap});
      axil_write(reg_tap_or, {30'b0, stim_table[e].taps.or_tap});
      expect_reg(reg_tap_data, {4'b0, stim_table[e].taps.data_tap}, "reg_tap_data");
      expect_reg(reg_tap_or, {30'b0, stim_table[e].taps.or_tap}, "reg_tap_or");
      run_entry(e);
      expect_reg(reg_status, {29'b0, sticky_b, sticky_a, 1'b0}, "sticky over-range");
      if (sticky_a || sticky_b) begin
        axil_write(reg_status, 32'h6);
        sticky_a = 1'b0;
        sticky_b = 1'b0;
        expect_reg(reg_status, 32'h0, "status after clear");
        repeat (4) @(negedge adc_div_clk);
        expect_reg(reg_status, 32'h0, "status stays clear");
      end
    end

    // valid must fall two edges after the control write is taken
    axil_write(reg_ctrl, 32'h0);
    waited = 0;
    while (adc_valid && waited < VALID_TIMEOUT) begin
      @(negedge adc_div_clk);
      waited++;
    end
    if (adc_valid) begin
      timeouts++;
      $display("timeout: adc_valid stayed high after capture was disabled");
    end else if (cycle_cnt - last_wr_edge != 2) begin
      mismatches++;
      $display("MISMATCH at %0t: adc_valid fell after %0d cycles, expected 2",
               $time, cycle_cnt - last_wr_edge);
    end

    // lock status through the synchronizer
    pll_locked = 1'b1;
    repeat (3) @(negedge adc_div_clk);
    expect_reg(reg_status, 32'h1, "status with pll locked");
    pll_locked = 1'b0;
    repeat (3) @(negedge adc_div_clk);
    expect_reg(reg_status, 32'h0, "status with pll unlocked");

    $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- flist.f
hw/adc_capture_pkg.sv
hw/adc_lane_align.sv
hw/adc_sample_demux.sv
hw/adc_if_core.sv
hw/adc_axil_regs.sv
hw/adc_capture_top.sv
test/adc_capture_tb.sv

//--- Makefile
# Verilator build and run of the adc capture testbench
# any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= adc_capture_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
